// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = frv_irq_tb
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log

SRCS     = $(shell cat $(FILELIST))
BIN      = $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: build.f
frv_irq_pkg.sv
frv_irq_if.sv
frv_interrupt.sv
frv_irq_csrs.sv
frv_irq_timer.sv
frv_irq_top.sv
frv_irq_tb.sv

// File: frv_interrupt.sv
//####################################################################
// Interrupt block
// Registers pending lines into mip, gates them with the enables and
// picks a prioritised cause for the trap request
//####################################################################
`timescale 1ns/1ps

module frv_interrupt (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    frv_irq_if.irq                 bus,
    input  logic                   nmi_pending,
    input  logic                   ex_pending,
    input  frv_irq_pkg::ex_cause_t ex_cause,
    input  logic                   ti_pending,
    input  logic                   sw_pending
);
    import frv_irq_pkg::*;

    logic        mip_nmi;      // NMI pending bit
    logic        raise_mei;
    logic        raise_mti;
    logic        raise_msi;
    logic        raise_nmi;
    trap_cause_t ext_cause;
    trap_cause_t next_cause;

    assign raise_mei = bus.mstatus_mie && bus.mie_meie && bus.mip_meip;
    assign raise_mti = bus.mstatus_mie && bus.mie_mtie && bus.mip_mtip;
    assign raise_msi = bus.mstatus_mie && bus.mie_msie && bus.mip_msip;
    assign raise_nmi = bus.mstatus_mie && mip_nmi;  // Only the global enable

    assign bus.int_trap_req = raise_mei || raise_mti || raise_msi || raise_nmi;

    // NMI code, then source supplied code, then the default external code
    always_comb begin
        if (nmi_pending) begin
            ext_cause = TRAP_INT_NMI;
        end else if (ex_cause != '0) begin
            ext_cause = TRAP_INT_EXT_BASE + trap_cause_t'(ex_cause);
        end else begin
            ext_cause = TRAP_INT_MEI;
        end
    end

    always_comb begin
        if (nmi_pending || ex_pending) begin
            next_cause = ext_cause;
        end else if (ti_pending) begin
            next_cause = TRAP_INT_MTI;
        end else if (sw_pending) begin
            next_cause = TRAP_INT_MSI;
        end else begin
            next_cause = '0;            // Nothing pending
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            bus.mip_meip       <= 1'b0;
            bus.mip_mtip       <= 1'b0;
            bus.mip_msip       <= 1'b0;
            mip_nmi            <= 1'b0;
            bus.int_trap_cause <= '0;
        end else begin
            bus.mip_meip       <= ex_pending;
            bus.mip_mtip       <= ti_pending;
            bus.mip_msip       <= sw_pending;
            mip_nmi            <= nmi_pending;
            bus.int_trap_cause <= next_cause;  // Same edge as mip
        end
    end

    // A request traces back to a line sampled on the previous edge
    a_req_has_source: assert property (@(posedge g_clk) disable iff (!g_resetn)
        bus.int_trap_req |-> $past(nmi_pending || ex_pending || ti_pending || sw_pending));

    a_cause_valid: assert property (@(posedge g_clk) disable iff (!g_resetn)
        bus.int_trap_req |-> bus.int_trap_cause != '0);

endmodule

// File: frv_irq_csrs.sv
//####################################################################
// Machine-mode interrupt CSRs
// mstatus MIE/MPIE, mie and mcause with CSR access, trap entry and mret
//####################################################################
`timescale 1ns/1ps

module frv_irq_csrs (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    frv_irq_if.ctrl                  bus,
    input  logic                     csr_we,
    input  logic                     mret,
    input  frv_irq_pkg::csr_addr_t   csr_addr,
    input  frv_irq_pkg::xlen_t       csr_wdata,
    output frv_irq_pkg::xlen_t       csr_rdata,
    output logic                     trap_taken,
    output frv_irq_pkg::trap_cause_t trap_cause
);
    import frv_irq_pkg::*;

    logic        mstatus_mpie;
    trap_cause_t mcause;
    logic        trap_enter;
    logic        wr_mstatus;
    logic        wr_mie;
    logic        wr_mcause;
    xlen_t       mstatus_rd;
    xlen_t       mie_rd;
    xlen_t       mip_rd;

    // Stands in for writeback, every request is accepted
    assign trap_enter       = bus.int_trap_req;
    assign bus.int_trap_ack = trap_enter;
    assign trap_taken       = trap_enter;
    assign trap_cause       = bus.int_trap_cause;

    assign wr_mstatus = csr_we && (csr_addr == CSR_MSTATUS);
    assign wr_mie     = csr_we && (csr_addr == CSR_MIE);
    assign wr_mcause  = csr_we && (csr_addr == CSR_MCAUSE);

    always_comb begin
        mstatus_rd                   = '0;
        mstatus_rd[MSTATUS_MIE_BIT]  = bus.mstatus_mie;
        mstatus_rd[MSTATUS_MPIE_BIT] = mstatus_mpie;
        mie_rd                       = '0;
        mie_rd[MIX_MSI_BIT]          = bus.mie_msie;
        mie_rd[MIX_MTI_BIT]          = bus.mie_mtie;
        mie_rd[MIX_MEI_BIT]          = bus.mie_meie;
        mip_rd                       = '0;
        mip_rd[MIX_MSI_BIT]          = bus.mip_msip;
        mip_rd[MIX_MTI_BIT]          = bus.mip_mtip;
        mip_rd[MIX_MEI_BIT]          = bus.mip_meip;
    end

    always_comb begin
        case (csr_addr)
            CSR_MSTATUS: csr_rdata = mstatus_rd;
            CSR_MIE:     csr_rdata = mie_rd;
            CSR_MIP:     csr_rdata = mip_rd;
            CSR_MCAUSE:  csr_rdata = xlen_t'(mcause);
            default:     csr_rdata = '0;  // Timer compare is write only
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            bus.mstatus_mie <= 1'b0;
            mstatus_mpie    <= 1'b0;
            bus.mie_meie    <= 1'b0;
            bus.mie_mtie    <= 1'b0;
            bus.mie_msie    <= 1'b0;
            mcause          <= '0;
        end else begin
            // Trap entry wins over mret and a software write
            if (trap_enter) begin
                bus.mstatus_mie <= 1'b0;
                mstatus_mpie    <= bus.mstatus_mie;
            end else if (mret) begin
                bus.mstatus_mie <= mstatus_mpie;
                mstatus_mpie    <= 1'b1;
            end else if (wr_mstatus) begin
                bus.mstatus_mie <= csr_wdata[MSTATUS_MIE_BIT];
                mstatus_mpie    <= csr_wdata[MSTATUS_MPIE_BIT];
            end

            if (wr_mie) begin
                bus.mie_msie <= csr_wdata[MIX_MSI_BIT];
                bus.mie_mtie <= csr_wdata[MIX_MTI_BIT];
                bus.mie_meie <= csr_wdata[MIX_MEI_BIT];
            end

            if (trap_enter) begin
                mcause <= bus.int_trap_cause;
            end else if (wr_mcause) begin
                mcause <= csr_wdata[$bits(trap_cause_t)-1:0];
            end
        end
    end

    // Clearing MIE drops the request after one cycle
    a_taken_one_cycle: assert property (@(posedge g_clk) disable iff (!g_resetn)
        trap_taken |=> !trap_taken);

    a_taken_with_mie: assert property (@(posedge g_clk) disable iff (!g_resetn)
        trap_taken |-> bus.mstatus_mie && !mret);

endmodule

// File: frv_irq_if.sv
//####################################################################
// Enable and pending bundle between the CSR and interrupt blocks
// Also carries the trap request, its cause and the acknowledge
//####################################################################
`timescale 1ns/1ps

interface frv_irq_if;
    import frv_irq_pkg::*;

    logic        mstatus_mie;     // Global interrupt enable
    logic        mie_meie;
    logic        mie_mtie;
    logic        mie_msie;
    logic        mip_meip;
    logic        mip_mtip;
    logic        mip_msip;
    logic        int_trap_req;    // Level, held until MIE clears
    trap_cause_t int_trap_cause;
    logic        int_trap_ack;    // Same cycle as the request

    modport ctrl (
        output mstatus_mie, mie_meie, mie_mtie, mie_msie, int_trap_ack,
        input  mip_meip, mip_mtip, mip_msip, int_trap_req, int_trap_cause
    );

    modport irq (
        input  mstatus_mie, mie_meie, mie_mtie, mie_msie, int_trap_ack,
        output mip_meip, mip_mtip, mip_msip, int_trap_req, int_trap_cause
    );

endinterface

// File: frv_irq_pkg.sv
//####################################################################
// Machine-mode interrupt definitions
// Cause codes, CSR addresses, bit positions and shared vector types
//####################################################################
package frv_irq_pkg;

    typedef logic [5:0]  trap_cause_t;  // Interrupt cause, as held in mcause
    typedef logic [3:0]  ex_cause_t;    // Cause from the external source, 0 = default
    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] xlen_t;

    // Interrupt cause codes
    localparam trap_cause_t TRAP_INT_MSI      = 6'd3;
    localparam trap_cause_t TRAP_INT_MTI      = 6'd7;
    localparam trap_cause_t TRAP_INT_MEI      = 6'd11;
    localparam trap_cause_t TRAP_INT_NMI      = 6'd15;
    localparam trap_cause_t TRAP_INT_EXT_BASE = 6'd16;  // Plus a nonzero ex_cause

    // CSR addresses
    localparam csr_addr_t CSR_MSTATUS     = 12'h300;
    localparam csr_addr_t CSR_MIE         = 12'h304;
    localparam csr_addr_t CSR_MCAUSE      = 12'h342;
    localparam csr_addr_t CSR_MIP         = 12'h344;
    localparam csr_addr_t CSR_MTIMECMP_LO = 12'h7C0;  // Custom machine space
    localparam csr_addr_t CSR_MTIMECMP_HI = 12'h7C1;

    // Bit positions in mstatus
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    // Shared bit positions in mie and mip
    localparam int MIX_MSI_BIT = 3;
    localparam int MIX_MTI_BIT = 7;
    localparam int MIX_MEI_BIT = 11;

endpackage

// File: frv_irq_tb.sv
//######################################################################
// Interrupt subsystem testbench
// Runs reset, timer, priority, masking and mret scenarios; concurrent
// assertions check the trap cause and the pulse width
//######################################################################
`timescale 1ns/1ps

module frv_irq_tb;
    import frv_irq_pkg::*;

    localparam int MAX_CYCLES = 2000;  // Far above the ~80 cycles all tests take

    logic        g_clk;
    logic        g_resetn;
    logic        csr_we;
    logic        mret;
    logic        nmi_pending;
    logic        ex_pending;
    logic        sw_pending;
    ex_cause_t   ex_cause;
    csr_addr_t   csr_addr;
    xlen_t       csr_wdata;
    xlen_t       csr_rdata;
    logic        trap_taken;
    trap_cause_t trap_cause;

    integer      seed = 32'h8d58;
    int          errors = 0;
    int          errors_at_start = 0;
    int          test_no = 0;
    int          test_fails = 0;
    int          cycles = 0;
    logic        tmr_exp = 1'b0;   // Timer compare already passed
    logic        quiet = 1'b0;     // No trap expected
    trap_cause_t exp_cause;
    trap_cause_t exp_cause_q;      // Value seen at the edge that registers the cause

    frv_irq_top #(.TIME_W(64)) dut0 (.*);

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;
    end

    // NMI first, then external, timer and software
    function automatic trap_cause_t prio_cause(input logic nmi, input logic ex,
                                               input ex_cause_t ec, input logic ti,
                                               input logic sw);
        if (nmi)
            return TRAP_INT_NMI;
        if (ex)
            return (ec == '0) ? TRAP_INT_MEI : TRAP_INT_EXT_BASE + trap_cause_t'(ec);
        if (ti)
            return TRAP_INT_MTI;
        if (sw)
            return TRAP_INT_MSI;
        return '0;
    endfunction

    always_comb exp_cause = prio_cause(nmi_pending, ex_pending, ex_cause, tmr_exp, sw_pending);

    always @(posedge g_clk) begin
        exp_cause_q <= exp_cause;
        cycles      <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped, no end reached within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    a_cause_on_rise: assert property (@(posedge g_clk) disable iff (!g_resetn)
        $rose(trap_taken) |-> trap_cause == exp_cause_q)
        else begin
            $display("[FAIL] trap_cause got %h exp %h", trap_cause, exp_cause_q);
            errors = errors + 1;
        end

    a_one_cycle: assert property (@(posedge g_clk) disable iff (!g_resetn)
        trap_taken |=> !trap_taken)
        else begin
            $display("trap_taken stayed high for more than one cycle");
            errors = errors + 1;
        end

    a_quiet: assert property (@(posedge g_clk) disable iff (!g_resetn)
        quiet |-> !trap_taken)
        else begin
            $display("trap_taken rose while no trap was expected");
            errors = errors + 1;
        end

    task automatic csr_write(input csr_addr_t addr, input xlen_t data);
        @(posedge g_clk);
        csr_we    <= 1'b1;
        csr_addr  <= addr;
        csr_wdata <= data;
        @(posedge g_clk);
        csr_we    <= 1'b0;
    endtask

    task automatic csr_check(input csr_addr_t addr, input xlen_t exp);
        @(posedge g_clk);
        csr_addr <= addr;
        @(negedge g_clk);
        assert (csr_rdata === exp)
        else begin
            $display("[FAIL] csr_rdata @%h got %h exp %h", addr, csr_rdata, exp);
            errors = errors + 1;
        end
    endtask

    task automatic set_lines(input logic nmi, input logic ex, input ex_cause_t ec,
                             input logic sw);
        @(posedge g_clk);
        nmi_pending <= nmi;
        ex_pending  <= ex;
        ex_cause    <= ec;
        sw_pending  <= sw;
    endtask

    task automatic wait_trap(input int limit);
        int n;
        n = 0;
        @(negedge g_clk);
        while (!trap_taken && n < limit) begin
            @(negedge g_clk);
            n++;
        end
        if (!trap_taken) begin
            $display("No trap_taken within %0d cycles", limit);
            errors = errors + 1;
        end
    endtask

    task automatic report_test(input string name);
        test_no++;
        if (errors == errors_at_start) begin
            $display("Test %0d %s: ok", test_no, name);
        end else begin
            test_fails++;
            $display("Test %0d %s: %0d errors", test_no, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin
        ex_cause_t ec;
        g_resetn    = 1'b0;
        csr_we      = 1'b0;
        mret        = 1'b0;
        nmi_pending = 1'b0;
        ex_pending  = 1'b0;
        sw_pending  = 1'b0;
        ex_cause    = '0;
        csr_addr    = '0;
        csr_wdata   = '0;
        quiet       = 1'b1;
        repeat (5) @(posedge g_clk);
        g_resetn <= 1'b1;

        csr_check(CSR_MSTATUS, '0);
        csr_check(CSR_MIP, '0);
        csr_check(CSR_MCAUSE, '0);
        repeat (10) @(posedge g_clk);
        quiet = 1'b0;
        report_test("reset state");

        // mtime is already past 4 when the compare lands
        csr_write(CSR_MTIMECMP_HI, '0);
        csr_write(CSR_MTIMECMP_LO, 32'd4);
        tmr_exp = 1'b1;
        csr_write(CSR_MIE, 32'h80);
        csr_write(CSR_MSTATUS, 32'h8);
        wait_trap(20);
        csr_check(CSR_MSTATUS, 32'h80);
        csr_check(CSR_MCAUSE, xlen_t'(TRAP_INT_MTI));
        csr_write(CSR_MTIMECMP_HI, '1);
        csr_write(CSR_MTIMECMP_LO, '1);
        csr_write(CSR_MIE, '0);
        tmr_exp = 1'b0;
        report_test("timer interrupt");

        // Random code, then the default code, then NMI on top
        csr_write(CSR_MIE, 32'h808);
        for (int r = 0; r < 3; r++) begin
            ec = (r == 1) ? ex_cause_t'(0) : ex_cause_t'($random(seed));
            set_lines(r == 2, 1'b1, ec, 1'b1);
            csr_write(CSR_MSTATUS, 32'h8);
            wait_trap(20);
            set_lines(1'b0, 1'b0, '0, 1'b0);
            repeat (3) @(posedge g_clk);
        end
        report_test("priority");

        quiet = 1'b1;
        csr_write(CSR_MIE, '0);
        csr_write(CSR_MSTATUS, 32'h8);
        set_lines(1'b0, 1'b0, '0, 1'b1);
        repeat (5) @(posedge g_clk);
        csr_check(CSR_MIP, 32'h8);
        quiet = 1'b0;
        csr_write(CSR_MIE, 32'h8);
        wait_trap(20);
        report_test("masking");

        // Software line still held, MPIE set by the last trap
        @(posedge g_clk);
        mret     <= 1'b1;
        csr_addr <= CSR_MSTATUS;
        @(posedge g_clk);
        mret     <= 1'b0;
        @(negedge g_clk);
        assert (trap_taken === 1'b1)
        else begin
            $display("No second trap_taken after mret");
            errors = errors + 1;
        end
        assert (csr_rdata === 32'h88)
        else begin
            $display("[FAIL] csr_rdata mstatus got %h exp %h", csr_rdata, 32'h88);
            errors = errors + 1;
        end
        csr_check(CSR_MSTATUS, 32'h80);
        csr_check(CSR_MCAUSE, xlen_t'(TRAP_INT_MSI));
        set_lines(1'b0, 1'b0, '0, 1'b0);
        repeat (3) @(posedge g_clk);
        report_test("mret");

        $display("Summary: %0d tests, %0d failed, %0d errors", test_no, test_fails, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: frv_irq_timer.sv
//####################################################################
// Machine timer
// Free-running mtime compared against a CSR-written mtimecmp
//####################################################################
`timescale 1ns/1ps

module frv_irq_timer #(
    parameter int TIME_W = 64  // Between 33 and 64 bits
) (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   csr_we,
    input  frv_irq_pkg::csr_addr_t csr_addr,
    input  frv_irq_pkg::xlen_t     csr_wdata,
    output logic                   ti_pending
);
    import frv_irq_pkg::*;

    localparam int HI_W = TIME_W - 32;  // Width of the upper compare half

    logic [TIME_W-1:0] mtime;
    logic [TIME_W-1:0] mtimecmp;
    logic              wr_lo;
    logic              wr_hi;

    assign wr_lo = csr_we && (csr_addr == CSR_MTIMECMP_LO);
    assign wr_hi = csr_we && (csr_addr == CSR_MTIMECMP_HI);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtime      <= '0;
            mtimecmp   <= '1;    // No timer interrupt out of reset
            ti_pending <= 1'b0;
        end else begin
            mtime <= mtime + 1'b1;
            if (wr_lo) begin
                mtimecmp[31:0] <= csr_wdata;
            end
            if (wr_hi) begin
                mtimecmp[TIME_W-1:32] <= csr_wdata[HI_W-1:0];
            end
            ti_pending <= (mtime >= mtimecmp);  // Level, held until compare moves
        end
    end

endmodule

// File: frv_irq_top.sv
//####################################################################
// Interrupt subsystem top level
// Timer, interrupt block and CSRs behind a plain CSR port
//####################################################################
`timescale 1ns/1ps

module frv_irq_top #(
    parameter int TIME_W = 64
) (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  logic                     csr_we,
    input  logic                     mret,
    input  logic                     nmi_pending,
    input  logic                     ex_pending,
    input  logic                     sw_pending,
    input  frv_irq_pkg::ex_cause_t   ex_cause,
    input  frv_irq_pkg::csr_addr_t   csr_addr,
    input  frv_irq_pkg::xlen_t       csr_wdata,
    output frv_irq_pkg::xlen_t       csr_rdata,
    output logic                     trap_taken,
    output frv_irq_pkg::trap_cause_t trap_cause
);

    frv_irq_if irq_bus ();

    logic ti_pending;  // Registered timer compare

    frv_irq_timer #(
        .TIME_W     (TIME_W)
    ) u_timer (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .csr_we     (csr_we),
        .csr_addr   (csr_addr),
        .csr_wdata  (csr_wdata),
        .ti_pending (ti_pending)
    );

    frv_interrupt u_interrupt (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .bus         (irq_bus.irq),
        .nmi_pending (nmi_pending),
        .ex_pending  (ex_pending),
        .ex_cause    (ex_cause),
        .ti_pending  (ti_pending),
        .sw_pending  (sw_pending)
    );

    frv_irq_csrs u_csrs (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .bus        (irq_bus.ctrl),
        .csr_we     (csr_we),
        .mret       (mret),
        .csr_addr   (csr_addr),
        .csr_wdata  (csr_wdata),
        .csr_rdata  (csr_rdata),
        .trap_taken (trap_taken),
        .trap_cause (trap_cause)
    );

endmodule
